// ==== Makefile ====
TOP = fp_alu_tb

.PHONY: compile run clean

compile:
	verilator --binary -Wno-fatal --top-module $(TOP) -f fp_alu.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/fp_adder.sv ====
module fp_adder (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic        subtract,
	output logic [31:0] sum
);
	import fp_pkg::*;

	fp_word_u ua;
	fp_word_u ub; // Carries the effective sign
	fp_word_u hi_op;
	fp_word_u lo_op;
	logic a_zero, b_zero;
	logic a_inf, b_inf;
	logic a_nan, b_nan;
	logic swap;
	logic eff_sub;
	logic [EXP_W-1:0] exp_diff;
	logic [26:0] hi_sig;
	logic [26:0] lo_sig;
	logic [27:0] raw;
	logic [4:0] lz;
	logic [27:0] norm;
	logic signed [9:0] exp_res;
	logic [31:0] arith;

	assign ua = a;
	assign ub = {b[31] ^ subtract, b[30:0]};

	// Exponent zero covers zero and subnormal alike
	assign a_zero = (ua.f.exp == '0);
	assign b_zero = (ub.f.exp == '0);
	assign a_inf  = (ua.f.exp == '1) && (ua.f.man == '0);
	assign b_inf  = (ub.f.exp == '1) && (ub.f.man == '0);
	assign a_nan  = (ua.f.exp == '1) && (ua.f.man != '0);
	assign b_nan  = (ub.f.exp == '1) && (ub.f.man != '0);

	//////////////////////////////////////////////////
	// Alignment
	assign swap    = {ub.f.exp, ub.f.man} > {ua.f.exp, ua.f.man};
	assign hi_op   = swap ? ub : ua;
	assign lo_op   = swap ? ua : ub;
	assign eff_sub = hi_op.f.sign ^ lo_op.f.sign;

	assign exp_diff = hi_op.f.exp - lo_op.f.exp;
	assign hi_sig   = {1'b1, hi_op.f.man, 3'b000};
	assign lo_sig   = {1'b1, lo_op.f.man, 3'b000} >> exp_diff; // Shifted-out bits lost

	// Larger magnitude first, so the difference never goes negative
	assign raw = eff_sub ? {1'b0, hi_sig} - {1'b0, lo_sig}
	                     : {1'b0, hi_sig} + {1'b0, lo_sig};

	//////////////////////////////////////////////////
	// Normalize
	always_comb begin
		lz = 5'd27;
		for (int i = 0; i < 28; i++) begin
			if (raw[i])
				lz = 5'(27 - i); // Highest set bit wins
		end
	end

	assign norm    = raw << lz;
	assign exp_res = $signed({2'b00, hi_op.f.exp}) + 10'sd1 - $signed({5'b00000, lz});

	always_comb begin
		if (raw == '0)
			arith = '0; // Exact cancellation gives +0
		else if (exp_res > 10'sd254)
			arith = {hi_op.f.sign, POS_INF[30:0]};
		else if (exp_res < 10'sd1)
			arith = {hi_op.f.sign, 31'd0};
		else
			arith = {hi_op.f.sign, exp_res[EXP_W-1:0], norm[26:4]};
	end

	//////////////////////////////////////////////////
	// Special operands
	always_comb begin
		if (a_nan || b_nan)
			sum = QNAN;
		else if (a_inf && b_inf)
			sum = (ua.f.sign != ub.f.sign) ? QNAN : ua;
		else if (a_inf)
			sum = ua;
		else if (b_inf)
			sum = ub;
		else if (a_zero && b_zero)
			sum = {ua.f.sign & ub.f.sign, 31'd0}; // -0 only for -0 plus -0
		else if (a_zero)
			sum = ub;
		else if (b_zero)
			sum = ua;
		else
			sum = arith;
	end

endmodule

// ==== design/fp_alu.sv ====
module fp_alu (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [3:0]  op,
	output logic [31:0] out,
	output logic        alu_err
);
	import fp_pkg::*;

	logic a_exp_min, a_exp_max, a_man_nz;
	logic b_exp_min, b_exp_max, b_man_nz;
	logic a_nan, b_nan;
	logic a_sign, b_sign;
	logic [30:0] a_mag, b_mag;
	logic cmp_eq, cmp_lt;
	logic [2:0] class_code;
	logic subtract;
	logic [31:0] add_a, add_b;
	logic [31:0] add_res;
	logic [31:0] mul_res;
	logic [31:0] conv_float, conv_int;
	logic [31:0] result;
	logic illegal;

	assign a_exp_min = (a[30:23] == 8'h00);
	assign a_exp_max = (a[30:23] == 8'hFF);
	assign a_man_nz  = |a[22:0];
	assign b_exp_min = (b[30:23] == 8'h00);
	assign b_exp_max = (b[30:23] == 8'hFF);
	assign b_man_nz  = |b[22:0];
	assign a_nan     = a_exp_max && a_man_nz;
	assign b_nan     = b_exp_max && b_man_nz;

	//////////////////////////////////////////////////
	// Datapath units
	assign subtract = (op == OP_SUB);
	assign add_a    = subtract ? b : a; // Swapped so the adder forms B - A
	assign add_b    = subtract ? a : b;

	fp_adder u_adder (
		.a        (add_a),
		.b        (add_b),
		.subtract (subtract),
		.sum      (add_res)
	);

	fp_multiplier u_mult (
		.a       (a),
		.b       (b),
		.product (mul_res)
	);

	fp_convert u_conv (
		.a        (a),
		.to_float (conv_float),
		.to_int   (conv_int)
	);

	//////////////////////////////////////////////////
	// Compare
	// Zeros and subnormals collapse to +0 here
	assign a_sign = a_exp_min ? 1'b0 : a[31];
	assign b_sign = b_exp_min ? 1'b0 : b[31];
	assign a_mag  = a_exp_min ? '0 : a[30:0];
	assign b_mag  = b_exp_min ? '0 : b[30:0];

	assign cmp_eq = !(a_nan || b_nan) && (a_sign == b_sign) && (a_mag == b_mag);

	always_comb begin
		if (a_nan || b_nan)
			cmp_lt = 1'b0; // Unordered
		else if (a_sign != b_sign)
			cmp_lt = a_sign;
		else if (a_sign)
			cmp_lt = a_mag > b_mag;
		else
			cmp_lt = a_mag < b_mag;
	end

	// Raw a, no flushing
	always_comb begin
		if (a_nan)
			class_code = CLS_NAN;
		else if (a_exp_max)
			class_code = CLS_INF;
		else if (a_exp_min && !a_man_nz)
			class_code = a[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
		else if (a_exp_min)
			class_code = a[31] ? CLS_NEG_SUB : CLS_POS_SUB;
		else
			class_code = a[31] ? CLS_NEG_NORM : CLS_POS_NORM;
	end

	//////////////////////////////////////////////////
	// Result select and output register
	always_comb begin
		illegal = 1'b0;
		case (op)
			OP_ADD, OP_SUB: result = add_res;
			OP_MUL:         result = mul_res;
			OP_EQ:          result = {31'd0, cmp_eq};
			OP_LE:          result = {31'd0, cmp_eq | cmp_lt};
			OP_LT:          result = {31'd0, cmp_lt};
			OP_I2F:         result = conv_float;
			OP_F2I:         result = conv_int;
			OP_CLASS:       result = {29'd0, class_code};
			OP_MOV:         result = a;
			default: begin
				result  = a; // Unknown op passes a and flags it
				illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out     <= '0;
			alu_err <= 1'b0;
		end else begin
			out     <= result;
			alu_err <= illegal;
		end
	end

endmodule

// ==== design/fp_convert.sv ====
module fp_convert (
	input  logic [31:0] a,
	output logic [31:0] to_float,
	output logic [31:0] to_int
);
	import fp_pkg::*;

	// Exponent at which the significand is an integer as it stands
	localparam logic [EXP_W-1:0] UNIT_EXP = 8'(EXP_BIAS + MAN_W);

	fp_word_u ua;
	logic int_neg;
	logic [31:0] int_mag;
	logic [4:0] msb;
	logic [31:0] int_norm;
	logic [EXP_W-1:0] i2f_exp;
	logic a_nan;
	logic [31:0] f2i_mag;

	assign ua = a;

	//////////////////////////////////////////////////
	// Integer to float
	assign int_neg = (ua.i < 0);
	assign int_mag = int_neg ? -ua.i : ua.i; // INT_MIN stays 2^31 unsigned

	always_comb begin
		msb = 5'd0;
		for (int i = 1; i < 32; i++) begin
			if (int_mag[i])
				msb = 5'(i);
		end
	end

	assign int_norm = int_mag << (5'd31 - msb); // Leading one to bit 31
	assign i2f_exp  = 8'(EXP_BIAS) + {3'b000, msb};
	assign to_float = (int_mag == '0) ? '0 : {int_neg, i2f_exp, int_norm[30:8]};

	//////////////////////////////////////////////////
	// Float to integer
	assign a_nan = (ua.f.exp == '1) && (ua.f.man != '0);

	assign f2i_mag = (ua.f.exp >= UNIT_EXP) ? {9'd1, ua.f.man} << (ua.f.exp - UNIT_EXP)
	                                        : {9'd1, ua.f.man} >> (UNIT_EXP - ua.f.exp);

	always_comb begin
		if (a_nan)
			to_int = INT_MIN;
		else if (ua.f.exp < 8'(EXP_BIAS))
			to_int = '0; // Below one, zero and subnormal
		else if (ua.f.exp >= 8'(EXP_BIAS + 31))
			to_int = ua.f.sign ? INT_MIN : INT_MAX; // Also catches infinity
		else
			to_int = ua.f.sign ? -f2i_mag : f2i_mag;
	end

endmodule

// ==== design/fp_multiplier.sv ====
module fp_multiplier (
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] product
);
	import fp_pkg::*;

	fp_word_u ua;
	fp_word_u ub;
	logic a_zero, b_zero;
	logic a_inf, b_inf;
	logic a_nan, b_nan;
	logic sign;
	logic [47:0] sig_prod;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_res;
	logic [MAN_W-1:0] man_res;

	assign ua = a;
	assign ub = b;

	assign a_zero = (ua.f.exp == '0); // Subnormals count as zero
	assign b_zero = (ub.f.exp == '0);
	assign a_inf  = (ua.f.exp == '1) && (ua.f.man == '0);
	assign b_inf  = (ub.f.exp == '1) && (ub.f.man == '0);
	assign a_nan  = (ua.f.exp == '1) && (ua.f.man != '0);
	assign b_nan  = (ub.f.exp == '1) && (ub.f.man != '0);

	assign sign     = ua.f.sign ^ ub.f.sign;
	assign sig_prod = {1'b1, ua.f.man} * {1'b1, ub.f.man};
	assign exp_sum  = $signed({2'b00, ua.f.exp}) + $signed({2'b00, ub.f.exp}) - 10'(EXP_BIAS);

	// Product of two values in [1,2) needs one shift at most
	always_comb begin
		if (sig_prod[47]) begin
			man_res = sig_prod[46:24];
			exp_res = exp_sum + 10'sd1;
		end else begin
			man_res = sig_prod[45:23];
			exp_res = exp_sum;
		end
	end

	always_comb begin
		if (a_nan || b_nan)
			product = QNAN;
		else if ((a_inf && b_zero) || (a_zero && b_inf))
			product = QNAN;
		else if (a_inf || b_inf)
			product = {sign, POS_INF[30:0]};
		else if (a_zero || b_zero)
			product = {sign, 31'd0};
		else if (exp_res > 10'sd254)
			product = {sign, POS_INF[30:0]}; // Overflow
		else if (exp_res < 10'sd1)
			product = {sign, 31'd0};         // Flush to zero
		else
			product = {sign, exp_res[EXP_W-1:0], man_res};
	end

endmodule

// ==== design/fp_pkg.sv ====
package fp_pkg;

	//////////////////////////////////////////////////
	// Opcode map
	localparam logic [3:0] OP_ADD   = 4'b0000;
	localparam logic [3:0] OP_SUB   = 4'b1111; // B minus A
	localparam logic [3:0] OP_MUL   = 4'b0010;
	localparam logic [3:0] OP_EQ    = 4'b1100;
	localparam logic [3:0] OP_LE    = 4'b1110;
	localparam logic [3:0] OP_LT    = 4'b1101;
	localparam logic [3:0] OP_I2F   = 4'b0100;
	localparam logic [3:0] OP_F2I   = 4'b0101;
	localparam logic [3:0] OP_CLASS = 4'b0110;
	localparam logic [3:0] OP_MOV   = 4'b0111;

	// Single precision layout
	localparam int EXP_W    = 8;
	localparam int MAN_W    = 23;
	localparam int EXP_BIAS = 127;

	// Classify results, zero-extended on the output
	localparam logic [2:0] CLS_INF      = 3'd0;
	localparam logic [2:0] CLS_NEG_NORM = 3'd1;
	localparam logic [2:0] CLS_NEG_SUB  = 3'd2;
	localparam logic [2:0] CLS_NEG_ZERO = 3'd3;
	localparam logic [2:0] CLS_POS_ZERO = 3'd4;
	localparam logic [2:0] CLS_POS_SUB  = 3'd5;
	localparam logic [2:0] CLS_POS_NORM = 3'd6;
	localparam logic [2:0] CLS_NAN      = 3'd7;

	localparam logic [31:0] QNAN    = 32'h7FC0_0000; // Canonical quiet NaN
	localparam logic [31:0] POS_INF = 32'h7F80_0000;
	localparam logic [31:0] INT_MAX = 32'h7FFF_FFFF;
	localparam logic [31:0] INT_MIN = 32'h8000_0000;

	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp_fields_t;

	// One word, read as float fields or as a signed integer
	typedef union packed {
		fp_fields_t         f;
		logic signed [31:0] i;
	} fp_word_u;

endpackage

// ==== fp_alu.f ====
+incdir+include
design/fp_pkg.sv
design/fp_adder.sv
design/fp_multiplier.sv
design/fp_convert.sv
design/fp_alu.sv
verification/tb_clock.sv
verification/fp_alu_tb.sv

// ==== include/fp_alu_ref.svh ====
`ifndef FP_ALU_REF_SVH
`define FP_ALU_REF_SVH

// Expected fp_alu behavior, included in a scope that imports fp_pkg::*

function automatic logic fp_ref_nan(input logic [31:0] w);
	return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
endfunction

// Zero and subnormal words become signed zero
function automatic logic [31:0] fp_ref_flush(input logic [31:0] w);
	return (w[30:23] == 8'd0) ? {w[31], 31'd0} : w;
endfunction

function automatic logic [31:0] fp_ref_pack(input logic s, input int e, input logic [22:0] m);
	if (e > 254) return {s, POS_INF[30:0]};
	if (e < 1) return {s, 31'd0};
	return {s, e[7:0], m};
endfunction

// y already carries the effective sign
function automatic logic [31:0] fp_ref_add(input logic [31:0] x, input logic [31:0] y);
	fp_word_u p;
	fp_word_u q;
	fp_word_u t;
	logic [27:0] s;
	int e;
	p = fp_ref_flush(x);
	q = fp_ref_flush(y);
	if (fp_ref_nan(x) || fp_ref_nan(y)) return QNAN;
	if (p.f.exp == 8'hFF && q.f.exp == 8'hFF) return (p.f.sign != q.f.sign) ? QNAN : p;
	if (p.f.exp == 8'hFF) return p;
	if (q.f.exp == 8'hFF) return q;
	if (p.f.exp == 8'd0) return (q.f.exp == 8'd0) ? {p.f.sign & q.f.sign, 31'd0} : q;
	if (q.f.exp == 8'd0) return p;
	if ({q.f.exp, q.f.man} > {p.f.exp, p.f.man}) begin
		t = p;
		p = q;
		q = t;
	end
	s = {1'b1, q.f.man, 3'b000} >> (p.f.exp - q.f.exp);
	s = (p.f.sign != q.f.sign) ? {1'b1, p.f.man, 3'b000} - s : {1'b1, p.f.man, 3'b000} + s;
	if (s == 28'd0) return 32'd0;
	e = p.f.exp + 1;
	while (!s[27]) begin
		s = s << 1;
		e--;
	end
	return fp_ref_pack(p.f.sign, e, s[26:4]);
endfunction

function automatic logic [31:0] fp_ref_mul(input logic [31:0] x, input logic [31:0] y);
	fp_word_u p;
	fp_word_u q;
	logic [47:0] m;
	logic s;
	int e;
	p = fp_ref_flush(x);
	q = fp_ref_flush(y);
	s = p.f.sign ^ q.f.sign;
	if (fp_ref_nan(x) || fp_ref_nan(y)) return QNAN;
	if ((p.f.exp == 8'hFF && q.f.exp == 8'd0) || (p.f.exp == 8'd0 && q.f.exp == 8'hFF))
		return QNAN;
	if (p.f.exp == 8'hFF || q.f.exp == 8'hFF) return {s, POS_INF[30:0]};
	if (p.f.exp == 8'd0 || q.f.exp == 8'd0) return {s, 31'd0};
	m = {1'b1, p.f.man} * {1'b1, q.f.man};
	e = p.f.exp + q.f.exp - EXP_BIAS;
	if (m[47]) begin
		m = m >> 1;
		e++;
	end
	return fp_ref_pack(s, e, m[45:23]);
endfunction

function automatic logic [31:0] fp_ref_i2f(input logic [31:0] x);
	fp_word_u w;
	logic [31:0] m;
	int e;
	w = x;
	if (w.i == 0) return 32'd0;
	m = (w.i < 0) ? -w.i : w.i;
	e = EXP_BIAS + 31;
	while (!m[31]) begin
		m = m << 1;
		e--;
	end
	return {w.i < 0, e[7:0], m[30:8]};
endfunction

function automatic logic [31:0] fp_ref_f2i(input logic [31:0] x);
	fp_word_u w;
	logic [31:0] m;
	w = x;
	if (fp_ref_nan(x)) return INT_MIN;
	if (w.f.exp < EXP_BIAS) return 32'd0;
	if (w.f.exp >= EXP_BIAS + 31) return w.f.sign ? INT_MIN : INT_MAX;
	m = {9'd1, w.f.man};
	if (w.f.exp >= EXP_BIAS + MAN_W)
		m = m << (w.f.exp - EXP_BIAS - MAN_W);
	else
		m = m >> (EXP_BIAS + MAN_W - w.f.exp);
	return w.f.sign ? -m : m;
endfunction

function automatic void fp_alu_expect(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] out, output logic err);
	logic [31:0] ka;
	logic [31:0] kb;
	logic unord;
	logic eq;
	logic lt;
	logic [2:0] cls;
	ka = (a[30:23] == 8'd0) ? 32'd0 : a; // Zeros compare as +0
	kb = (b[30:23] == 8'd0) ? 32'd0 : b;
	unord = fp_ref_nan(a) || fp_ref_nan(b);
	eq = !unord && (ka == kb);
	if (unord) lt = 1'b0;
	else if (ka[31] != kb[31]) lt = ka[31];
	else lt = ka[31] ? (ka[30:0] > kb[30:0]) : (ka[30:0] < kb[30:0]);
	if (fp_ref_nan(a)) cls = CLS_NAN;
	else if (a[30:23] == 8'hFF) cls = CLS_INF;
	else if (a[30:0] == 31'd0) cls = a[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
	else if (a[30:23] == 8'd0) cls = a[31] ? CLS_NEG_SUB : CLS_POS_SUB;
	else cls = a[31] ? CLS_NEG_NORM : CLS_POS_NORM;
	err = 1'b0;
	case (op)
		OP_ADD:   out = fp_ref_add(a, b);
		OP_SUB:   out = fp_ref_add(b, {~a[31], a[30:0]});
		OP_MUL:   out = fp_ref_mul(a, b);
		OP_EQ:    out = {31'd0, eq};
		OP_LE:    out = {31'd0, eq | lt};
		OP_LT:    out = {31'd0, lt};
		OP_I2F:   out = fp_ref_i2f(a);
		OP_F2I:   out = fp_ref_f2i(a);
		OP_CLASS: out = {29'd0, cls};
		OP_MOV:   out = a;
		default: begin
			out = a;
			err = 1'b1;
		end
	endcase
endfunction

`endif

// ==== verification/fp_alu_tb.sv ====
module fp_alu_tb;
	import fp_pkg::*;

	`include "fp_alu_ref.svh"

	localparam int CLK_PERIOD   = 8;
	localparam int DRIVE_DELAY  = 1;
	localparam int SLACK_CYCLES = 20; // Reset, latency and margin

	logic        clk;
	logic        rst_n;
	logic [31:0] a;
	logic [31:0] b;
	logic [3:0]  op;
	logic [31:0] out;
	logic        alu_err;

	logic [3:0]  op_q[$];
	logic [31:0] a_q[$];
	logic [31:0] b_q[$];
	logic        built = 1'b0;
	logic [15:0] lfsr = 16'd57548;

	// Expectation for the operation now on the inputs
	logic [31:0] pend_out;
	logic        pend_err;
	logic        pend_valid;
	logic [3:0]  chk_op;
	logic [31:0] chk_a;
	logic [31:0] chk_b;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fp_alu uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.a       (a),
		.b       (b),
		.op      (op),
		.out     (out),
		.alu_err (alu_err)
	);

	//////////////////////////////////////////////////
	// Random operands
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11 + 1
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// Exponent kept around 2^-15 .. 2^16
	function automatic logic [31:0] rand_float();
		logic [31:0] s;
		logic [31:0] e;
		logic [31:0] m;
		s = rand_bits(1);
		e = rand_bits(5);
		m = rand_bits(23);
		return {s[0], 8'(112 + e), m[22:0]};
	endfunction

	//////////////////////////////////////////////////
	// Checks
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_result(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("ERR %s: expected %h, got %h (op %h, a %h, b %h)",
				name, expected, actual, chk_op, chk_a, chk_b));
	endtask

	task automatic check_err(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("ERR %s: expected %h, got %h (op %h, a %h, b %h)",
				name, expected, actual, chk_op, chk_a, chk_b));
	endtask

	//////////////////////////////////////////////////
	// Test list
	task automatic add_op(input logic [3:0] o, input logic [31:0] x, input logic [31:0] y);
		op_q.push_back(o);
		a_q.push_back(x);
		b_q.push_back(y);
	endtask

	task automatic build_tests();
		logic [3:0]  cmp_ops [3];
		logic [31:0] cmp_a [9];
		logic [31:0] cmp_b [9];
		logic [31:0] cls_a [8];
		logic [3:0]  bad_ops [6];
		cmp_ops = '{OP_EQ, OP_LE, OP_LT};
		cmp_a = '{32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000, 32'h3F80_0000, 32'hBF80_0000,
			32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, 32'h0000_0001};
		cmp_b = '{32'h8000_0000, 32'h0000_0000, 32'h3F80_0000, 32'h7FC0_0000, 32'h3F80_0000,
			32'hBF80_0000, 32'hBF80_0000, 32'h3F80_0000, 32'h8000_0000};
		cls_a = '{32'hFF80_0000, 32'hBF80_0000, 32'h8040_0000, 32'h8000_0000,
			32'h0000_0000, 32'h0000_0001, 32'h3F80_0000, 32'h7FC0_0001};
		bad_ops = '{4'b0001, 4'b0011, 4'b1000, 4'b1001, 4'b1010, 4'b1011};

		add_op(OP_ADD, 32'h3F80_0000, 32'h3FC0_0000); // Equal exponents
		add_op(OP_ADD, 32'h4B80_0000, 32'h3F80_0000); // Gap of 24
		add_op(OP_ADD, 32'h3F80_0000, 32'h0C80_0000);
		add_op(OP_SUB, 32'h4040_0000, 32'h4040_0000); // Cancels to +0
		add_op(OP_SUB, 32'h3F80_0000, 32'h4040_0000);
		add_op(OP_SUB, 32'h00C0_0000, 32'h0080_0000); // Underflow flush
		add_op(OP_ADD, 32'h7F7F_FFFF, 32'h7F7F_FFFF); // Overflow
		add_op(OP_ADD, 32'h7F80_0000, 32'hFF80_0000);
		add_op(OP_SUB, 32'h7F80_0000, 32'h7F80_0000);
		add_op(OP_ADD, 32'h8000_0000, 32'h8000_0000);
		add_op(OP_ADD, 32'h0000_0000, 32'h8000_0000);
		add_op(OP_ADD, 32'h0000_0001, 32'h3F80_0000);
		add_op(OP_ADD, 32'h7F80_0001, 32'h3F80_0000);
		for (int j = 0; j < 200; j++)
			add_op(j[0] ? OP_SUB : OP_ADD, rand_float(), rand_float());

		add_op(OP_MUL, 32'h3FC0_0000, 32'h4000_0000);
		add_op(OP_MUL, 32'h4040_0000, 32'hBF80_0000);
		add_op(OP_MUL, 32'h7F00_0000, 32'h4000_0000); // Overflow
		add_op(OP_MUL, 32'h0080_0000, 32'h0080_0000); // Underflow
		add_op(OP_MUL, 32'h0000_0000, 32'h7F80_0000);
		add_op(OP_MUL, 32'h7F80_0000, 32'hBF80_0000);
		add_op(OP_MUL, 32'hFFC0_0001, 32'h3F80_0000);
		add_op(OP_MUL, 32'h8000_0001, 32'h4000_0000);
		for (int j = 0; j < 100; j++)
			add_op(OP_MUL, rand_float(), rand_float());

		add_op(OP_I2F, 32'h0000_0000, '0);
		add_op(OP_I2F, 32'hFFFF_FFFF, '0);
		add_op(OP_I2F, 32'h8000_0000, '0);
		add_op(OP_I2F, 32'h7FFF_FFFF, '0);
		add_op(OP_I2F, 32'hFFFF_FF85, '0);
		for (int j = 0; j < 40; j++)
			add_op(OP_I2F, rand_bits(32), '0);
		add_op(OP_F2I, 32'h3FC0_0000, '0);
		add_op(OP_F2I, 32'hBFC0_0000, '0);
		add_op(OP_F2I, 32'h3F00_0000, '0);
		add_op(OP_F2I, 32'h4F00_0000, '0); // 2^31 saturates
		add_op(OP_F2I, 32'hCF00_0000, '0);
		add_op(OP_F2I, 32'h4EFF_FFFF, '0);
		add_op(OP_F2I, 32'h7FC0_0000, '0);
		add_op(OP_F2I, 32'h0000_0001, '0);
		add_op(OP_F2I, 32'h8040_0000, '0);
		for (int j = 0; j < 40; j++)
			add_op(OP_F2I, rand_float(), '0);

		foreach (cmp_ops[k]) begin
			foreach (cmp_a[j])
				add_op(cmp_ops[k], cmp_a[j], cmp_b[j]);
			for (int j = 0; j < 40; j++)
				add_op(cmp_ops[k], j[0] ? rand_bits(32) : rand_float(), rand_float());
		end
		foreach (cls_a[j])
			add_op(OP_CLASS, cls_a[j], rand_bits(32));

		// Illegal opcodes mixed with legal ones
		add_op(OP_MOV, 32'h1234_5678, 32'hFFFF_FFFF);
		foreach (bad_ops[k]) begin
			add_op(bad_ops[k], rand_bits(32), rand_bits(32));
			add_op(OP_MUL, rand_float(), rand_float());
		end
		add_op(bad_ops[0], rand_bits(32), rand_bits(32));
		add_op(bad_ops[5], rand_bits(32), rand_bits(32));
		add_op(OP_ADD, rand_float(), rand_float());
	endtask

	//////////////////////////////////////////////////
	// Driver, compare and watchdog
	initial begin : driver
		op = 4'b1000; // Illegal op, so reset must also hold alu_err low
		a = 32'hA5A5_0F0F; // Nonzero so reset visibly clears out
		b = '0;
		pend_valid = 1'b0;
		build_tests();
		built = 1'b1;
		wait (rst_n === 1'b1);
		foreach (op_q[i]) begin
			op = op_q[i];
			a = a_q[i];
			b = b_q[i];
			fp_alu_expect(op_q[i], a_q[i], b_q[i], pend_out, pend_err);
			pend_valid = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		pend_valid = 1'b0;
		@(negedge clk);
		#DRIVE_DELAY;
		$display("STATUS: PASS");
		$finish;
	end

	initial begin : compare
		logic        cap_rst;
		logic        cap_valid;
		logic [31:0] cap_out;
		logic        cap_err;
		forever begin
			@(posedge clk);
			cap_rst = rst_n;
			cap_valid = pend_valid;
			cap_out = pend_out;
			cap_err = pend_err;
			chk_op = op;
			chk_a = a;
			chk_b = b;
			@(negedge clk);
			if (!cap_rst) begin
				check_result("out", 32'd0, out);
				check_err("alu_err", 1'b0, alu_err);
			end else if (cap_valid) begin
				check_result("out", cap_out, out);
				check_err("alu_err", cap_err, alu_err);
			end
		end
	end

	initial begin : watchdog
		wait (built);
		#((op_q.size() + SLACK_CYCLES) * CLK_PERIOD);
		abort_run("Timeout: the operation list did not finish in the expected time");
	end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int PERIOD       = 8;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1; // Released just after the last reset edge
	end

endmodule
